//--- Makefile
TOP = tb_adc_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- hdl/adc_channel.sv
`timescale 1ns/1ps
`default_nettype none

module adc_channel #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                           up_clk,
  input  logic                           up_rstn,
  input  logic                           adc_rst,
  input  logic                           adc_valid,
  input  logic [2*adc_pkg::SAMPLE_W-1:0] adc_data,
  input  logic [1:0]                     adc_or,
  output logic [adc_pkg::UP_DATA_W-1:0]  adc_dfmt_data,
  output logic                           adc_dfmt_valid,
  output logic                           adc_enable,
  output logic                           up_adc_or,
  output logic                           up_adc_ramp_err,
  input  logic                           up_wreq,
  input  logic [adc_pkg::UP_ADDR_W-1:0]  up_waddr,
  input  logic [adc_pkg::UP_DATA_W-1:0]  up_wdata,
  output logic                           up_wack,
  input  logic                           up_rreq,
  input  logic [adc_pkg::UP_ADDR_W-1:0]  up_raddr,
  output logic [adc_pkg::UP_DATA_W-1:0]  up_rdata,
  output logic                           up_rack
);

  logic [adc_pkg::UP_ADDR_W-1:0] chan_base;
  logic                          wr_sel;
  logic                          rd_sel;
  logic [2:0]                    ctrl;
  logic [2:0]                    ctrl_next;
  logic [1:0]                    status;
  logic [1:0]                    status_clr;
  logic [1:0]                    status_set;
  logic [adc_pkg::SAMPLE_W-1:0]  s0;
  logic [adc_pkg::SAMPLE_W-1:0]  s1;
  logic [adc_pkg::SAMPLE_W-1:0]  prev_s1;
  logic                          ramp_armed;
  logic                          ramp_bad;

  // offset binary to two's complement by msb flip
  function automatic logic [adc_pkg::OUT_SAMPLE_W-1:0] fmt(
    input logic [adc_pkg::SAMPLE_W-1:0] s, input logic tc);
    fmt = tc ? {{3{~s[13]}}, s[12:0]} : {2'b00, s};
  endfunction

  assign chan_base = adc_pkg::CHAN_BASE +
                     adc_pkg::CHAN_STRIDE * (adc_pkg::UP_ADDR_W)'(CHANNEL_ID);
  assign wr_sel = up_wreq && (up_waddr[13:4] == chan_base[13:4]);
  assign rd_sel = up_rreq && (up_raddr[13:4] == chan_base[13:4]);

  assign s0 = adc_data[13:0];
  assign s1 = adc_data[27:14];
  assign ramp_bad = (s1 != s0 + 14'd1) || (s0 != prev_s1 + 14'd1);

  always_comb begin
    ctrl_next  = ctrl;
    status_clr = 2'b00;
    if (wr_sel && up_waddr[3:0] == adc_pkg::CHAN_CTRL) ctrl_next = up_wdata[2:0];
    if (wr_sel && up_waddr[3:0] == adc_pkg::CHAN_STATUS) status_clr = up_wdata[1:0];
    status_set[0] = adc_valid && (|adc_or);
    status_set[1] = adc_valid && ctrl[2] && ramp_armed && ramp_bad;
  end

  assign adc_enable      = ctrl[0];
  assign up_adc_or       = status[0];
  assign up_adc_ramp_err = status[1];

  // ******************************************************************
  // sample path

  always_ff @(posedge up_clk) begin
    if (adc_rst) begin
      adc_dfmt_valid <= 1'b0;
      adc_dfmt_data  <= '0;
    end else begin
      adc_dfmt_valid <= adc_valid && ctrl_next[0];
      adc_dfmt_data  <= {fmt(s1, ctrl[1]), fmt(s0, ctrl[1])};
    end
  end

  // ramp history, first frame after enabling only arms the check
  always_ff @(posedge up_clk) begin
    if (adc_valid) prev_s1 <= s1;
  end

  // ******************************************************************
  // registers

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      ctrl       <= 3'b000;
      status     <= 2'b00;
      ramp_armed <= 1'b0;
      up_wack    <= 1'b0;
      up_rack    <= 1'b0;
      up_rdata   <= '0;
    end else begin
      ctrl       <= ctrl_next;
      status     <= (status & ~status_clr) | status_set;
      ramp_armed <= ctrl[2] && (ramp_armed || adc_valid);
      up_wack    <= wr_sel;
      up_rack    <= rd_sel;
      up_rdata   <= '0;
      if (rd_sel) begin
        case (up_raddr[3:0])
          adc_pkg::CHAN_CTRL:   up_rdata <= {29'd0, ctrl};
          adc_pkg::CHAN_STATUS: up_rdata <= {30'd0, status};
          default:              up_rdata <= '0;
        endcase
      end
    end
  end

  // a disabled channel never presents data
  assert property (@(posedge up_clk) disable iff (!up_rstn || adc_rst)
    adc_dfmt_valid |-> adc_enable);

endmodule

`default_nettype wire

//--- hdl/adc_common.sv
`timescale 1ns/1ps
`default_nettype none

module adc_common (
  input  logic                          up_clk,
  input  logic                          up_rstn,
  input  logic                          adc_dovf,
  input  logic                          adc_dunf,
  input  logic                          up_status_or,
  input  logic                          up_status_ramp_err,
  output logic                          adc_rst,
  input  logic                          up_wreq,
  input  logic [adc_pkg::UP_ADDR_W-1:0] up_waddr,
  input  logic [adc_pkg::UP_DATA_W-1:0] up_wdata,
  output logic                          up_wack,
  input  logic                          up_rreq,
  input  logic [adc_pkg::UP_ADDR_W-1:0] up_raddr,
  output logic [adc_pkg::UP_DATA_W-1:0] up_rdata,
  output logic                          up_rack
);

  logic                          wr_sel;
  logic                          rd_sel;
  logic [adc_pkg::UP_DATA_W-1:0] scratch;
  logic                          run;
  logic [1:0]                    dma_status;
  logic [1:0]                    dma_clr;

  // common window is 0x000 to 0x0ff
  assign wr_sel  = up_wreq && (up_waddr[13:8] == 6'd0);
  assign rd_sel  = up_rreq && (up_raddr[13:8] == 6'd0);
  assign dma_clr = (wr_sel && up_waddr == adc_pkg::ADDR_DMA_STATUS) ? up_wdata[1:0] : 2'b00;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      scratch    <= '0;
      run        <= 1'b0;
      dma_status <= 2'b00;
      adc_rst    <= 1'b1;
      up_wack    <= 1'b0;
      up_rack    <= 1'b0;
      up_rdata   <= '0;
    end else begin
      if (wr_sel && up_waddr == adc_pkg::ADDR_SCRATCH) scratch <= up_wdata;
      if (wr_sel && up_waddr == adc_pkg::ADDR_RSTN) run <= up_wdata[0];
      // sticky, a new event wins over the clear
      dma_status <= (dma_status & ~dma_clr) | {adc_dunf, adc_dovf};
      adc_rst    <= ~run;
      up_wack    <= wr_sel;
      up_rack    <= rd_sel;
      up_rdata   <= '0;
      if (rd_sel) begin
        case (up_raddr)
          adc_pkg::ADDR_VERSION:    up_rdata <= adc_pkg::CORE_VERSION;
          adc_pkg::ADDR_ID:         up_rdata <= adc_pkg::CORE_ID;
          adc_pkg::ADDR_SCRATCH:    up_rdata <= scratch;
          adc_pkg::ADDR_RSTN:       up_rdata <= {31'd0, run};
          adc_pkg::ADDR_DMA_STATUS: up_rdata <= {30'd0, dma_status};
          adc_pkg::ADDR_SUMMARY:    up_rdata <= {30'd0, up_status_ramp_err, up_status_or};
          default:                  up_rdata <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/adc_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_core_top (
  input  logic                        up_clk,
  input  logic                        up_rstn,
  input  logic                        rx_valid,
  input  logic [adc_pkg::FRAME_W-1:0] rx_data,
  output logic                        rx_ready,
  output logic                        adc_rst,
  output logic                        adc_valid_a,
  output logic                        adc_enable_a,
  output logic [31:0]                 adc_data_a,
  output logic                        adc_valid_b,
  output logic                        adc_enable_b,
  output logic [31:0]                 adc_data_b,
  input  logic                        adc_dovf,
  input  logic                        adc_dunf,
  input  logic                        s_axi_awvalid,
  input  logic [31:0]                 s_axi_awaddr,
  output logic                        s_axi_awready,
  input  logic                        s_axi_wvalid,
  input  logic [31:0]                 s_axi_wdata,
  input  logic [3:0]                  s_axi_wstrb,
  output logic                        s_axi_wready,
  output logic                        s_axi_bvalid,
  output logic [1:0]                  s_axi_bresp,
  input  logic                        s_axi_bready,
  input  logic                        s_axi_arvalid,
  input  logic [31:0]                 s_axi_araddr,
  output logic                        s_axi_arready,
  output logic                        s_axi_rvalid,
  output logic [31:0]                 s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  input  logic                        s_axi_rready
);

  logic                          adc_valid_s;
  logic [27:0]                   adc_data_a_s;
  logic [27:0]                   adc_data_b_s;
  logic [1:0]                    adc_or_a_s;
  logic [1:0]                    adc_or_b_s;
  logic [1:0]                    up_or_s;
  logic [1:0]                    up_ramp_err_s;
  logic                          up_status_or;
  logic                          up_status_ramp_err;
  logic [adc_pkg::UP_DATA_W-1:0] up_rdata_s [0:2];
  logic [2:0]                    up_rack_s;
  logic [2:0]                    up_wack_s;
  logic [adc_pkg::UP_DATA_W-1:0] up_rdata;
  logic                          up_rack;
  logic                          up_wack;
  logic                          up_wreq;
  logic [adc_pkg::UP_ADDR_W-1:0] up_waddr;
  logic [adc_pkg::UP_DATA_W-1:0] up_wdata;
  logic                          up_rreq;
  logic [adc_pkg::UP_ADDR_W-1:0] up_raddr;

  // the sample stream never stalls
  assign rx_ready = 1'b1;

  // merged register bus returns, one cycle
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rdata           <= '0;
      up_rack            <= 1'b0;
      up_wack            <= 1'b0;
      up_status_or       <= 1'b0;
      up_status_ramp_err <= 1'b0;
    end else begin
      up_rdata           <= up_rdata_s[0] | up_rdata_s[1] | up_rdata_s[2];
      up_rack            <= |up_rack_s;
      up_wack            <= |up_wack_s;
      up_status_or       <= |up_or_s;
      up_status_ramp_err <= |up_ramp_err_s;
    end
  end

  // ******************************************************************
  // device interface and channels

  adc_rx_if i_if (
    .up_clk (up_clk),
    .adc_rst (adc_rst),
    .rx_valid (rx_valid),
    .rx_data (rx_data),
    .adc_valid (adc_valid_s),
    .adc_data_a (adc_data_a_s),
    .adc_data_b (adc_data_b_s),
    .adc_or_a (adc_or_a_s),
    .adc_or_b (adc_or_b_s));

  adc_channel #(.CHANNEL_ID (0)) i_channel_0 (
    .up_clk (up_clk),
    .up_rstn (up_rstn),
    .adc_rst (adc_rst),
    .adc_valid (adc_valid_s),
    .adc_data (adc_data_a_s),
    .adc_or (adc_or_a_s),
    .adc_dfmt_data (adc_data_a),
    .adc_dfmt_valid (adc_valid_a),
    .adc_enable (adc_enable_a),
    .up_adc_or (up_or_s[0]),
    .up_adc_ramp_err (up_ramp_err_s[0]),
    .up_wreq (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack (up_wack_s[0]),
    .up_rreq (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata_s[0]),
    .up_rack (up_rack_s[0]));

  adc_channel #(.CHANNEL_ID (1)) i_channel_1 (
    .up_clk (up_clk),
    .up_rstn (up_rstn),
    .adc_rst (adc_rst),
    .adc_valid (adc_valid_s),
    .adc_data (adc_data_b_s),
    .adc_or (adc_or_b_s),
    .adc_dfmt_data (adc_data_b),
    .adc_dfmt_valid (adc_valid_b),
    .adc_enable (adc_enable_b),
    .up_adc_or (up_or_s[1]),
    .up_adc_ramp_err (up_ramp_err_s[1]),
    .up_wreq (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack (up_wack_s[1]),
    .up_rreq (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata_s[1]),
    .up_rack (up_rack_s[1]));

  // ******************************************************************
  // common registers and bus bridge

  adc_common i_common (
    .up_clk (up_clk),
    .up_rstn (up_rstn),
    .adc_dovf (adc_dovf),
    .adc_dunf (adc_dunf),
    .up_status_or (up_status_or),
    .up_status_ramp_err (up_status_ramp_err),
    .adc_rst (adc_rst),
    .up_wreq (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack (up_wack_s[2]),
    .up_rreq (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata_s[2]),
    .up_rack (up_rack_s[2]));

  up_axi_lite i_up_axi (
    .up_clk (up_clk),
    .up_rstn (up_rstn),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_awready (s_axi_awready),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wdata (s_axi_wdata),
    .s_axi_wstrb (s_axi_wstrb),
    .s_axi_wready (s_axi_wready),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bresp (s_axi_bresp),
    .s_axi_bready (s_axi_bready),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_arready (s_axi_arready),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rdata (s_axi_rdata),
    .s_axi_rresp (s_axi_rresp),
    .s_axi_rready (s_axi_rready),
    .up_wreq (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack (up_wack),
    .up_rreq (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack (up_rack));

  // address windows must not overlap
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    $onehot0(up_rack_s) && $onehot0(up_wack_s));

endmodule

`default_nettype wire

//--- hdl/adc_pkg.sv
`default_nettype none

package adc_pkg;

  // ******************************************************************
  // widths

  localparam int UP_ADDR_W    = 14;
  localparam int UP_DATA_W    = 32;
  localparam int SAMPLE_W     = 14;
  localparam int OUT_SAMPLE_W = 16;
  localparam int FRAME_W      = 64;

  // identity
  localparam logic [UP_DATA_W-1:0] CORE_VERSION = 32'h0001_0a61;
  localparam logic [UP_DATA_W-1:0] CORE_ID      = 32'h0000_0e14;

  // ******************************************************************
  // register map, word addresses

  localparam logic [UP_ADDR_W-1:0] ADDR_VERSION    = 14'h000;
  localparam logic [UP_ADDR_W-1:0] ADDR_ID         = 14'h001;
  localparam logic [UP_ADDR_W-1:0] ADDR_SCRATCH    = 14'h002;
  localparam logic [UP_ADDR_W-1:0] ADDR_RSTN       = 14'h010;
  localparam logic [UP_ADDR_W-1:0] ADDR_DMA_STATUS = 14'h017;
  localparam logic [UP_ADDR_W-1:0] ADDR_SUMMARY    = 14'h018;

  // channel windows, 16 words each
  localparam logic [UP_ADDR_W-1:0] CHAN_BASE   = 14'h100;
  localparam logic [UP_ADDR_W-1:0] CHAN_STRIDE = 14'h010;
  localparam logic [3:0]           CHAN_CTRL   = 4'h0;
  localparam logic [3:0]           CHAN_STATUS = 4'h1;

  // bus constants
  localparam int         UP_ACK_TIMEOUT = 8;
  localparam logic [1:0] RESP_OKAY      = 2'b00;
  localparam logic [1:0] RESP_SLVERR    = 2'b10;

  // one frame word, as delivered and as lanes
  // lane: sample in 15:2, over-range in 0
  typedef union packed {
    logic [7:0][7:0]  octets;
    logic [3:0][15:0] lanes;
  } rx_frame_u;

endpackage

`default_nettype wire

//--- hdl/adc_rx_if.sv
`timescale 1ns/1ps
`default_nettype none

module adc_rx_if (
  input  logic                         up_clk,
  input  logic                         adc_rst,
  input  logic                         rx_valid,
  input  logic [adc_pkg::FRAME_W-1:0]  rx_data,
  output logic                         adc_valid,
  output logic [2*adc_pkg::SAMPLE_W-1:0] adc_data_a,
  output logic [2*adc_pkg::SAMPLE_W-1:0] adc_data_b,
  output logic [1:0]                   adc_or_a,
  output logic [1:0]                   adc_or_b
);

  adc_pkg::rx_frame_u frame_in;
  adc_pkg::rx_frame_u frame_ln;

  // octet 2k is the upper byte of lane k
  always_comb begin
    frame_in = rx_data;
    for (int k = 0; k < 4; k++) begin
      frame_ln.lanes[k] = {frame_in.octets[2*k], frame_in.octets[2*k+1]};
    end
  end

  // lanes 0/1 to channel a, lanes 2/3 to channel b
  always_ff @(posedge up_clk) begin
    if (adc_rst) begin
      adc_valid  <= 1'b0;
      adc_data_a <= '0;
      adc_data_b <= '0;
      adc_or_a   <= 2'b00;
      adc_or_b   <= 2'b00;
    end else begin
      adc_valid  <= rx_valid;
      adc_data_a <= {frame_ln.lanes[1][15:2], frame_ln.lanes[0][15:2]};
      adc_data_b <= {frame_ln.lanes[3][15:2], frame_ln.lanes[2][15:2]};
      adc_or_a   <= {frame_ln.lanes[1][0], frame_ln.lanes[0][0]};
      adc_or_b   <= {frame_ln.lanes[3][0], frame_ln.lanes[2][0]};
    end
  end

endmodule

`default_nettype wire

//--- hdl/up_axi_lite.sv
`timescale 1ns/1ps
`default_nettype none

module up_axi_lite (
  input  logic                          up_clk,
  input  logic                          up_rstn,
  input  logic                          s_axi_awvalid,
  input  logic [31:0]                   s_axi_awaddr,
  output logic                          s_axi_awready,
  input  logic                          s_axi_wvalid,
  input  logic [31:0]                   s_axi_wdata,
  input  logic [3:0]                    s_axi_wstrb,
  output logic                          s_axi_wready,
  output logic                          s_axi_bvalid,
  output logic [1:0]                    s_axi_bresp,
  input  logic                          s_axi_bready,
  input  logic                          s_axi_arvalid,
  input  logic [31:0]                   s_axi_araddr,
  output logic                          s_axi_arready,
  output logic                          s_axi_rvalid,
  output logic [31:0]                   s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  input  logic                          s_axi_rready,
  output logic                          up_wreq,
  output logic [adc_pkg::UP_ADDR_W-1:0] up_waddr,
  output logic [adc_pkg::UP_DATA_W-1:0] up_wdata,
  input  logic                          up_wack,
  output logic                          up_rreq,
  output logic [adc_pkg::UP_ADDR_W-1:0] up_raddr,
  input  logic [adc_pkg::UP_DATA_W-1:0] up_rdata,
  input  logic                          up_rack
);

  logic       wr_pend;
  logic       rd_pend;
  logic       idle;
  logic       timeout;
  logic [3:0] timer;

  assign idle    = !(wr_pend || rd_pend || s_axi_bvalid || s_axi_rvalid);
  assign timeout = (timer == 4'(adc_pkg::UP_ACK_TIMEOUT));

  // request address and data, byte address to word address
  always_ff @(posedge up_clk) begin
    if (idle && s_axi_awvalid && s_axi_wvalid) begin
      up_waddr <= s_axi_awaddr[adc_pkg::UP_ADDR_W+1:2];
      up_wdata <= s_axi_wdata;
    end
    if (idle && s_axi_arvalid) up_raddr <= s_axi_araddr[adc_pkg::UP_ADDR_W+1:2];
  end

  // ******************************************************************
  // one transaction at a time, writes first

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_arready <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      s_axi_bresp   <= adc_pkg::RESP_OKAY;
      s_axi_rvalid  <= 1'b0;
      s_axi_rresp   <= adc_pkg::RESP_OKAY;
      s_axi_rdata   <= '0;
      wr_pend       <= 1'b0;
      rd_pend       <= 1'b0;
      up_wreq       <= 1'b0;
      up_rreq       <= 1'b0;
      timer         <= 4'd0;
    end else begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_arready <= 1'b0;
      up_wreq       <= 1'b0;
      up_rreq       <= 1'b0;
      timer         <= timer + 4'd1;
      if (idle && s_axi_awvalid && s_axi_wvalid) begin
        s_axi_awready <= 1'b1;
        s_axi_wready  <= 1'b1;
        wr_pend       <= 1'b1;
        up_wreq       <= 1'b1;
        timer         <= 4'd0;
      end else if (idle && s_axi_arvalid) begin
        s_axi_arready <= 1'b1;
        rd_pend       <= 1'b1;
        up_rreq       <= 1'b1;
        timer         <= 4'd0;
      end
      // ack or give up after the timeout
      if (wr_pend && (up_wack || timeout)) begin
        wr_pend      <= 1'b0;
        s_axi_bvalid <= 1'b1;
        s_axi_bresp  <= up_wack ? adc_pkg::RESP_OKAY : adc_pkg::RESP_SLVERR;
      end
      if (rd_pend && (up_rack || timeout)) begin
        rd_pend      <= 1'b0;
        s_axi_rvalid <= 1'b1;
        s_axi_rresp  <= up_rack ? adc_pkg::RESP_OKAY : adc_pkg::RESP_SLVERR;
        s_axi_rdata  <= up_rack ? up_rdata : '0;
      end
      if (s_axi_bvalid && s_axi_bready) s_axi_bvalid <= 1'b0;
      if (s_axi_rvalid && s_axi_rready) s_axi_rvalid <= 1'b0;
    end
  end

  assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);
  // registers take full words only
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    idle && s_axi_awvalid && s_axi_wvalid |-> s_axi_wstrb == 4'hf);

endmodule

`default_nettype wire

//--- list.f
+incdir+test
hdl/adc_pkg.sv
hdl/adc_rx_if.sv
hdl/adc_channel.sv
hdl/adc_common.sv
hdl/up_axi_lite.sv
hdl/adc_core_top.sv
test/tb_adc_core.sv

//--- test/tb_adc_tasks.svh
// ********************************************************************
// failure reporting and compares

task automatic stop_with_failure(input string reason);
  $display("%s", reason);
  $display("tests failed");
  $fatal(1);
endtask

task automatic check_word(input string what, input logic [adc_pkg::UP_DATA_W-1:0] exp,
                          input logic [adc_pkg::UP_DATA_W-1:0] act);
  if (act !== exp) begin
    stop_with_failure($sformatf("MISMATCH %s %s expected %h actual %h",
                                test_name, what, exp, act));
  end
endtask

task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
  if (act !== exp) begin
    stop_with_failure($sformatf("MISMATCH %s %s expected %b actual %b",
                                test_name, what, exp, act));
  end
endtask

function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// ********************************************************************
// AXI4-lite master taking word addresses

task automatic axi_write(input logic [adc_pkg::UP_ADDR_W-1:0] addr,
                         input logic [adc_pkg::UP_DATA_W-1:0] data, output logic [1:0] resp);
  int n;
  @(posedge up_clk);
  s_axi_awvalid <= 1'b1;
  s_axi_wvalid  <= 1'b1;
  s_axi_awaddr  <= {16'd0, addr, 2'b00};
  s_axi_wdata   <= data;
  s_axi_bready  <= 1'b1;
  n = 0;
  do begin
    @(posedge up_clk);
    n++;
  end while (!s_axi_awready && n < 32);
  if (!s_axi_awready) stop_with_failure("timeout waiting for awready");
  if (!s_axi_wready) stop_with_failure("wready did not pulse together with awready");
  s_axi_awvalid <= 1'b0;
  s_axi_wvalid  <= 1'b0;
  n = 0;
  do begin
    @(posedge up_clk);
    n++;
  end while (!s_axi_bvalid && n < 32);
  if (!s_axi_bvalid) stop_with_failure("timeout waiting for bvalid");
  resp = s_axi_bresp;
  s_axi_bready <= 1'b0;
endtask

task automatic axi_read(input logic [adc_pkg::UP_ADDR_W-1:0] addr,
                        output logic [adc_pkg::UP_DATA_W-1:0] data, output logic [1:0] resp);
  int n;
  @(posedge up_clk);
  s_axi_arvalid <= 1'b1;
  s_axi_araddr  <= {16'd0, addr, 2'b00};
  s_axi_rready  <= 1'b1;
  n = 0;
  do begin
    @(posedge up_clk);
    n++;
  end while (!s_axi_arready && n < 32);
  if (!s_axi_arready) stop_with_failure("timeout waiting for arready");
  s_axi_arvalid <= 1'b0;
  n = 0;
  do begin
    @(posedge up_clk);
    n++;
  end while (!s_axi_rvalid && n < 32);
  if (!s_axi_rvalid) stop_with_failure("timeout waiting for rvalid");
  data = s_axi_rdata;
  resp = s_axi_rresp;
  s_axi_rready <= 1'b0;
endtask

task automatic write_reg(input logic [adc_pkg::UP_ADDR_W-1:0] addr,
                         input logic [adc_pkg::UP_DATA_W-1:0] data);
  logic [1:0] resp;
  axi_write(addr, data, resp);
  check_resp("write response", adc_pkg::RESP_OKAY, resp);
endtask

task automatic read_reg(input logic [adc_pkg::UP_ADDR_W-1:0] addr,
                        output logic [adc_pkg::UP_DATA_W-1:0] data);
  logic [1:0] resp;
  axi_read(addr, data, resp);
  check_resp("read response", adc_pkg::RESP_OKAY, resp);
endtask

function automatic logic [adc_pkg::UP_ADDR_W-1:0] chan_addr(input logic ch,
                                                            input logic [3:0] off);
  return adc_pkg::CHAN_BASE + (ch ? adc_pkg::CHAN_STRIDE : 14'd0) + {10'd0, off};
endfunction

// ********************************************************************
// frames and expected samples

// lanes 0 and 1 feed channel a and lanes 2 and 3 channel b
// the high octet of lane k comes first on the link
function automatic adc_pkg::rx_frame_u make_frame(input logic [3:0][13:0] s,
                                                  input logic [3:0] ovr);
  adc_pkg::rx_frame_u f;
  logic [15:0]        lane;
  for (int k = 0; k < 4; k++) begin
    lane = {s[k], 1'b0, ovr[k]};
    f.octets[2*k]   = lane[15:8];
    f.octets[2*k+1] = lane[7:0];
  end
  return f;
endfunction

function automatic logic [3:0][13:0] random_samples();
  logic [3:0][13:0] s;
  logic [31:0]      r;
  for (int k = 0; k < 4; k++) begin
    r = next_random();
    s[k] = r[13:0];
  end
  return s;
endfunction

// offset binary to two's complement is an msb flip
function automatic logic [adc_pkg::OUT_SAMPLE_W-1:0] format_sample(input logic [13:0] s,
                                                                  input logic tc);
  logic [13:0] v;
  v = s ^ 14'h2000;
  if (tc) return {{2{v[13]}}, v};
  else return {2'b00, s};
endfunction

task automatic send_frame(input adc_pkg::rx_frame_u f);
  @(posedge up_clk);
  rx_valid <= 1'b1;
  rx_data  <= f;
  @(posedge up_clk);
  rx_valid <= 1'b0;
endtask

task automatic pulse_dma(input logic ovf, input logic unf);
  @(posedge up_clk);
  adc_dovf <= ovf;
  adc_dunf <= unf;
  @(posedge up_clk);
  adc_dovf <= 1'b0;
  adc_dunf <= 1'b0;
endtask

// ********************************************************************
// directed tests

task automatic reset_and_identity();
  logic [31:0] d;
  logic [31:0] w;
  test_name = "reset_and_identity";
  @(negedge up_clk);
  check_word("adc_rst", 32'd1, {31'd0, adc_rst});
  check_word("rx_ready", 32'd1, {31'd0, rx_ready});
  check_word("valid a", 32'd0, {31'd0, adc_valid_a});
  check_word("enable a", 32'd0, {31'd0, adc_enable_a});
  check_word("enable b", 32'd0, {31'd0, adc_enable_b});
  read_reg(adc_pkg::ADDR_VERSION, d);
  check_word("version", adc_pkg::CORE_VERSION, d);
  read_reg(adc_pkg::ADDR_ID, d);
  check_word("core id", adc_pkg::CORE_ID, d);
  repeat (4) begin
    w = next_random();
    write_reg(adc_pkg::ADDR_SCRATCH, w);
    read_reg(adc_pkg::ADDR_SCRATCH, d);
    check_word("scratch", w, d);
  end
  write_reg(adc_pkg::ADDR_RSTN, 32'd1);
  @(negedge up_clk);
  check_word("adc_rst after run", 32'd0, {31'd0, adc_rst});
endtask

task automatic sample_mapping();
  logic [3:0][13:0] s;
  logic             tc;
  test_name = "sample_mapping";
  for (int i = 0; i < 2; i++) begin
    tc = (i == 1);
    write_reg(chan_addr(1'b0, adc_pkg::CHAN_CTRL), {29'd0, 1'b0, tc, 1'b1});
    write_reg(chan_addr(1'b1, adc_pkg::CHAN_CTRL), {29'd0, 1'b0, tc, 1'b1});
    repeat (8) begin
      s = random_samples();
      send_frame(make_frame(s, 4'b0000));
      // output is registered two edges after the frame
      @(posedge up_clk);
      @(negedge up_clk);
      check_word("valid a", 32'd1, {31'd0, adc_valid_a});
      check_word("valid b", 32'd1, {31'd0, adc_valid_b});
      check_word("data a", {format_sample(s[1], tc), format_sample(s[0], tc)}, adc_data_a);
      check_word("data b", {format_sample(s[3], tc), format_sample(s[2], tc)}, adc_data_b);
    end
  end
  // channel b off while a keeps running
  write_reg(chan_addr(1'b1, adc_pkg::CHAN_CTRL), 32'd0);
  s = random_samples();
  send_frame(make_frame(s, 4'b0000));
  @(posedge up_clk);
  @(negedge up_clk);
  check_word("valid a", 32'd1, {31'd0, adc_valid_a});
  check_word("enable a", 32'd1, {31'd0, adc_enable_a});
  check_word("valid b disabled", 32'd0, {31'd0, adc_valid_b});
  check_word("enable b", 32'd0, {31'd0, adc_enable_b});
  @(negedge up_clk);
  check_word("valid a after frame", 32'd0, {31'd0, adc_valid_a});
endtask

task automatic over_range_status();
  logic [3:0][13:0] s;
  logic [31:0]      d;
  test_name = "over_range_status";
  s = random_samples();
  // lane 3 is channel b sample 1
  send_frame(make_frame(s, 4'b1000));
  read_reg(chan_addr(1'b1, adc_pkg::CHAN_STATUS), d);
  check_word("status b", 32'd1, d);
  read_reg(chan_addr(1'b0, adc_pkg::CHAN_STATUS), d);
  check_word("status a", 32'd0, d);
  read_reg(adc_pkg::ADDR_SUMMARY, d);
  check_word("summary", 32'd1, d);
  write_reg(chan_addr(1'b1, adc_pkg::CHAN_STATUS), 32'd1);
  read_reg(chan_addr(1'b1, adc_pkg::CHAN_STATUS), d);
  check_word("status b cleared", 32'd0, d);
  read_reg(adc_pkg::ADDR_SUMMARY, d);
  check_word("summary cleared", 32'd0, d);
endtask

task automatic ramp_monitor();
  logic [3:0][13:0] s;
  logic [13:0]      a;
  logic [13:0]      b;
  logic [31:0]      d;
  test_name = "ramp_monitor";
  write_reg(chan_addr(1'b0, adc_pkg::CHAN_CTRL), 32'h5);
  write_reg(chan_addr(1'b1, adc_pkg::CHAN_CTRL), 32'h5);
  // channel a ramp wraps through zero
  a = 14'h3ff8;
  b = 14'h0123;
  repeat (6) begin
    s = {b + 14'd1, b, a + 14'd1, a};
    send_frame(make_frame(s, 4'b0000));
    a = a + 14'd2;
    b = b + 14'd2;
  end
  read_reg(chan_addr(1'b0, adc_pkg::CHAN_STATUS), d);
  check_word("status a ramp ok", 32'd0, d);
  read_reg(chan_addr(1'b1, adc_pkg::CHAN_STATUS), d);
  check_word("status b ramp ok", 32'd0, d);
  a = a + 14'd1;
  s = {b + 14'd1, b, a + 14'd1, a};
  send_frame(make_frame(s, 4'b0000));
  read_reg(chan_addr(1'b0, adc_pkg::CHAN_STATUS), d);
  check_word("status a skipped", 32'd2, d);
  read_reg(chan_addr(1'b1, adc_pkg::CHAN_STATUS), d);
  check_word("status b untouched", 32'd0, d);
  read_reg(adc_pkg::ADDR_SUMMARY, d);
  check_word("summary ramp", 32'd2, d);
  write_reg(chan_addr(1'b0, adc_pkg::CHAN_STATUS), 32'd2);
  read_reg(chan_addr(1'b0, adc_pkg::CHAN_STATUS), d);
  check_word("status a cleared", 32'd0, d);
endtask

task automatic dma_and_bus_errors();
  logic [31:0] d;
  logic [1:0]  resp;
  test_name = "dma_and_bus_errors";
  pulse_dma(1'b1, 1'b0);
  read_reg(adc_pkg::ADDR_DMA_STATUS, d);
  check_word("overflow", 32'd1, d);
  write_reg(adc_pkg::ADDR_DMA_STATUS, 32'd1);
  read_reg(adc_pkg::ADDR_DMA_STATUS, d);
  check_word("overflow cleared", 32'd0, d);
  pulse_dma(1'b0, 1'b1);
  read_reg(adc_pkg::ADDR_DMA_STATUS, d);
  check_word("underflow", 32'd2, d);
  write_reg(adc_pkg::ADDR_DMA_STATUS, 32'd2);
  read_reg(adc_pkg::ADDR_DMA_STATUS, d);
  check_word("underflow cleared", 32'd0, d);
  // nobody answers 0x300
  axi_read(14'h300, d, resp);
  check_resp("unmapped response", adc_pkg::RESP_SLVERR, resp);
  check_word("unmapped data", 32'd0, d);
  read_reg(adc_pkg::ADDR_VERSION, d);
  check_word("version after error", adc_pkg::CORE_VERSION, d);
endtask

//--- test/tb_adc_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_core;

  logic                        up_clk;
  logic                        up_rstn;
  logic                        rx_valid;
  logic [adc_pkg::FRAME_W-1:0] rx_data;
  logic                        rx_ready;
  logic                        adc_rst;
  logic                        adc_valid_a;
  logic                        adc_enable_a;
  logic [31:0]                 adc_data_a;
  logic                        adc_valid_b;
  logic                        adc_enable_b;
  logic [31:0]                 adc_data_b;
  logic                        adc_dovf;
  logic                        adc_dunf;
  logic                        s_axi_awvalid;
  logic [31:0]                 s_axi_awaddr;
  logic                        s_axi_awready;
  logic                        s_axi_wvalid;
  logic [31:0]                 s_axi_wdata;
  logic [3:0]                  s_axi_wstrb;
  logic                        s_axi_wready;
  logic                        s_axi_bvalid;
  logic [1:0]                  s_axi_bresp;
  logic                        s_axi_bready;
  logic                        s_axi_arvalid;
  logic [31:0]                 s_axi_araddr;
  logic                        s_axi_arready;
  logic                        s_axi_rvalid;
  logic [31:0]                 s_axi_rdata;
  logic [1:0]                  s_axi_rresp;
  logic                        s_axi_rready;

  // xorshift state and the name of the running test
  logic [31:0]                 rng_state;
  string                       test_name;

  adc_core_top adc_core_top_i (.*);

  initial begin
    up_clk = 1'b0;
    forever #50 up_clk = ~up_clk;
  end

  `include "tb_adc_tasks.svh"

  // ********************************************************************
  // test sequence

  initial begin
    rng_state     = 32'd58488;
    test_name     = "startup";
    up_rstn       <= 1'b0;
    rx_valid      <= 1'b0;
    rx_data       <= '0;
    adc_dovf      <= 1'b0;
    adc_dunf      <= 1'b0;
    s_axi_awvalid <= 1'b0;
    s_axi_awaddr  <= '0;
    s_axi_wvalid  <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= 4'hf;
    s_axi_bready  <= 1'b0;
    s_axi_arvalid <= 1'b0;
    s_axi_araddr  <= '0;
    s_axi_rready  <= 1'b0;
    repeat (2) @(posedge up_clk);
    up_rstn <= 1'b1;
    reset_and_identity();
    sample_mapping();
    over_range_status();
    ramp_monitor();
    dma_and_bus_errors();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
